// ==== source/tl_pkg.sv ====
package tl_pkg;

localparam int WORD_SIZE   = 32;
localparam int OFFSET_SIZE = 4;                        // 16-byte cache line
localparam int TAG_SIZE    = WORD_SIZE - OFFSET_SIZE;
localparam int REG_SIZE    = 5;

typedef logic [WORD_SIZE-1:0] word_t;                  // Data, addresses and pc
typedef logic [REG_SIZE-1:0]  reg_addr_t;
typedef logic [TAG_SIZE-1:0]  line_tag_t;              // Address without line offset

typedef enum logic [1:0] {
    TL_IDLE,
    TL_MISS_WAIT,                                      // Waiting for a line fill
    TL_SB_FULL                                         // Draining to make room for a store
} tl_state_e;

// Execute to tag lookup
typedef struct packed {
    word_t     alu_res;                                // Address or ALU result
    word_t     st_data;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      memop_rd;
    logic      memop_wr;
    logic      tkbr;
    word_t     new_pc;
} ex_tl_t;

// Tag lookup to memory stage
typedef struct packed {
    word_t     alu_res;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      tkbr;
    word_t     new_pc;
    logic      memop_rd;
    logic      memop_wr;
    word_t     mem_addr;
    word_t     mem_data;
    logic      sb_hit;                                 // Load served by the store buffer
} tl_mem_t;

endpackage : tl_pkg

// ==== source/dcache_tag.sv ====
module dcache_tag #(
    parameter int  NUM_LINES = 4,
    localparam int SLOT_W    = (NUM_LINES > 1) ? $clog2(NUM_LINES) : 1
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // Lookup
    input  tl_pkg::line_tag_t lookup_tag_i,
    output logic              hit_o,
    // Fill from the memory side
    input  logic              fill_i,
    input  tl_pkg::line_tag_t fill_tag_i,
    input  logic [SLOT_W-1:0] fill_slot_i
);

import tl_pkg::*;

line_tag_t            tags_q [NUM_LINES];
logic [NUM_LINES-1:0] valid_q;
logic [NUM_LINES-1:0] match;

// Compare against every slot in parallel
always_comb begin : tag_compare
    for (int i = 0; i < NUM_LINES; i++) begin
        match[i] = valid_q[i] && (tags_q[i] == lookup_tag_i);
    end
end

assign hit_o = |match;

always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_reg
    if (!arst_n_i) begin
        valid_q <= '0;                                 // All lines invalid
    end else begin
        if (fill_i) begin
            valid_q[fill_slot_i] <= 1'b1;
        end
    end
end

// Victim slot is picked by the memory side
always_ff @(posedge clk_i) begin : tag_store
    if (fill_i) begin
        tags_q[fill_slot_i] <= fill_tag_i;
    end
end

endmodule : dcache_tag

// ==== source/store_buffer.sv ====
module store_buffer #(
    parameter int  SB_DEPTH = 4,
    localparam int PTR_W    = (SB_DEPTH > 1) ? $clog2(SB_DEPTH) : 1,
    localparam int CNT_W    = $clog2(SB_DEPTH + 1)
) (
    input  logic          clk_i,
    input  logic          arst_n_i,
    // Retiring stores
    input  logic          push_i,
    input  tl_pkg::word_t push_addr_i,
    input  tl_pkg::word_t push_data_i,
    // Drain toward the memory stage
    input  logic          pop_i,
    // Load forwarding
    input  tl_pkg::word_t lookup_addr_i,
    output logic          fwd_hit_o,
    output tl_pkg::word_t fwd_data_o,
    // Status and head entry
    output logic          full_o,
    output logic          not_empty_o,
    output tl_pkg::word_t head_addr_o,
    output tl_pkg::word_t head_data_o
);

import tl_pkg::*;

localparam int BYTE_BITS = 2;                          // Word aligned accesses only

word_t             addr_q [SB_DEPTH];
word_t             data_q [SB_DEPTH];
logic [PTR_W-1:0]  wr_ptr_q;
logic [PTR_W-1:0]  rd_ptr_q;
logic [CNT_W-1:0]  count_q;

function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(SB_DEPTH - 1)) begin
        return '0;
    end
    return ptr + 1'b1;
endfunction

assign full_o      = (count_q == CNT_W'(SB_DEPTH));
assign not_empty_o = (count_q != '0);
assign head_addr_o = addr_q[rd_ptr_q];
assign head_data_o = data_q[rd_ptr_q];

// Newest entry first, so the latest store to a word wins
always_comb begin : fwd_search
    int   idx;
    logic found;
    found      = 1'b0;
    fwd_data_o = '0;
    for (int age = 0; age < SB_DEPTH; age++) begin
        idx = int'(wr_ptr_q) - 1 - age;
        if (idx < 0) begin
            idx = idx + SB_DEPTH;                      // Wrap around the ring
        end
        if (!found && (age < int'(count_q)) &&
            (addr_q[idx][WORD_SIZE-1:BYTE_BITS] == lookup_addr_i[WORD_SIZE-1:BYTE_BITS])) begin
            found      = 1'b1;
            fwd_data_o = data_q[idx];
        end
    end
    fwd_hit_o = found;
end

always_ff @(posedge clk_i or negedge arst_n_i) begin : ptr_reg
    if (!arst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
    end else begin
        if (push_i) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (pop_i) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        // Simultaneous push and pop leaves the count unchanged
        if (push_i && !pop_i) begin
            count_q <= count_q + 1'b1;
        end else if (pop_i && !push_i) begin
            count_q <= count_q - 1'b1;
        end
    end
end

always_ff @(posedge clk_i) begin : entry_store
    if (push_i) begin
        addr_q[wr_ptr_q] <= push_addr_i;
        data_q[wr_ptr_q] <= push_data_i;
    end
end

endmodule : store_buffer

// ==== source/tl_stage.sv ====
module tl_stage #(
    parameter int  NUM_LINES = 4,
    parameter int  SB_DEPTH  = 4,
    localparam int SLOT_W    = (NUM_LINES > 1) ? $clog2(NUM_LINES) : 1
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // Execute side
    input  tl_pkg::ex_tl_t    ex_tl_i,
    output logic              stall_o,
    // Memory stage side
    output tl_pkg::tl_mem_t   tl_mem_o,
    // Line fill handshake
    output logic              mmu_req_o,
    output tl_pkg::word_t     mmu_addr_o,
    input  logic              mmu_rdy_i,
    input  logic [SLOT_W-1:0] mmu_victim_i
);

import tl_pkg::*;

tl_state_e state_q;
tl_state_e state_d;
line_tag_t in_tag;
logic      is_rd;
logic      is_wr;
logic      tag_hit;
logic      sb_fwd_hit;
word_t     sb_fwd_data;
logic      sb_full;
logic      sb_not_empty;
word_t     sb_head_addr;
word_t     sb_head_data;
logic      load_miss;
logic      store_blocked;
logic      sb_push;
logic      sb_pop;
logic      stall;
tl_mem_t   out_d;
tl_mem_t   out_q;

assign in_tag = ex_tl_i.alu_res[WORD_SIZE-1:OFFSET_SIZE];
assign is_rd  = ex_tl_i.memop_rd;
assign is_wr  = ex_tl_i.memop_wr;

// Store buffer is checked before the tags
assign load_miss     = is_rd && !sb_fwd_hit && !tag_hit;
assign store_blocked = is_wr && sb_full;

assign sb_push = (state_q == TL_IDLE) && is_wr && !sb_full;
assign sb_pop  = sb_not_empty &&
                 (((state_q == TL_IDLE) && !is_rd && !is_wr) || (state_q == TL_SB_FULL));

assign mmu_req_o  = ((state_q == TL_IDLE) && load_miss) || (state_q == TL_MISS_WAIT);
assign mmu_addr_o = {in_tag, {OFFSET_SIZE{1'b0}}};    // Line address

assign stall_o  = stall;
assign tl_mem_o = out_q;

dcache_tag #(
    .NUM_LINES (NUM_LINES)
) u_dcache_tag (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .lookup_tag_i (in_tag),
    .hit_o        (tag_hit),
    .fill_i       (mmu_rdy_i),
    .fill_tag_i   (mmu_addr_o[WORD_SIZE-1:OFFSET_SIZE]),
    .fill_slot_i  (mmu_victim_i)
);

store_buffer #(
    .SB_DEPTH (SB_DEPTH)
) u_store_buffer (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .push_i        (sb_push),
    .push_addr_i   (ex_tl_i.alu_res),
    .push_data_i   (ex_tl_i.st_data),
    .pop_i         (sb_pop),
    .lookup_addr_i (ex_tl_i.alu_res),
    .fwd_hit_o     (sb_fwd_hit),
    .fwd_data_o    (sb_fwd_data),
    .full_o        (sb_full),
    .not_empty_o   (sb_not_empty),
    .head_addr_o   (sb_head_addr),
    .head_data_o   (sb_head_data)
);

always_comb begin : tl_fsm
    state_d = state_q;
    stall   = 1'b1;
    case (state_q)
        TL_IDLE: begin
            stall = load_miss || store_blocked;
            if (load_miss) begin
                state_d = TL_MISS_WAIT;
            end else if (store_blocked) begin
                state_d = TL_SB_FULL;
            end
        end
        TL_MISS_WAIT: begin
            if (mmu_rdy_i) begin
                state_d = TL_IDLE;                     // Load replays and hits next cycle
            end
        end
        TL_SB_FULL: begin
            // One drain frees a slot for the held store
            if (sb_pop) begin
                state_d = TL_IDLE;
            end
        end
        default: state_d = TL_IDLE;
    endcase
end

always_comb begin : out_select
    out_d          = out_q;
    out_d.rf_we    = 1'b0;                             // Bubble unless accepted
    out_d.memop_rd = 1'b0;
    out_d.memop_wr = 1'b0;
    out_d.tkbr     = 1'b0;
    out_d.sb_hit   = 1'b0;
    if (!stall) begin
        out_d.alu_res  = ex_tl_i.alu_res;
        out_d.rf_we    = ex_tl_i.rf_we;
        out_d.rf_waddr = ex_tl_i.rf_waddr;
        out_d.tkbr     = ex_tl_i.tkbr;
        out_d.new_pc   = ex_tl_i.new_pc;
        out_d.mem_addr = ex_tl_i.alu_res;
        out_d.mem_data = ex_tl_i.st_data;
        if (is_rd) begin
            if (sb_fwd_hit) begin
                out_d.sb_hit   = 1'b1;
                out_d.mem_data = sb_fwd_data;          // No cache read needed
            end else begin
                out_d.memop_rd = 1'b1;
            end
        end
    end
    // Drained entry goes to memory as a write
    if (sb_pop) begin
        out_d.memop_wr = 1'b1;
        out_d.mem_addr = sb_head_addr;
        out_d.mem_data = sb_head_data;
    end
end

always_ff @(posedge clk_i or negedge arst_n_i) begin : stage_reg
    if (!arst_n_i) begin
        state_q <= TL_IDLE;
        out_q   <= '0;
    end else begin
        state_q <= state_d;
        out_q   <= out_d;
    end
end

endmodule : tl_stage

// ==== dv/mmu_model.sv ====
module mmu_model #(
    parameter int  NUM_LINES = 4,
    localparam int SLOT_W    = (NUM_LINES > 1) ? $clog2(NUM_LINES) : 1
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              mmu_req_i,
    output logic              mmu_rdy_o,
    output logic [SLOT_W-1:0] mmu_victim_o
);

timeunit 1ns;
timeprecision 100ps;

integer            seed = 40910;
int                wait_cnt;
logic              busy;
logic [SLOT_W-1:0] next_victim;                        // Round-robin pointer

always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
        busy         <= 1'b0;
        wait_cnt     <= 0;
        mmu_rdy_o    <= 1'b0;
        mmu_victim_o <= '0;
        next_victim  <= '0;
    end else begin
        mmu_rdy_o <= 1'b0;
        if (!busy && mmu_req_i && !mmu_rdy_o) begin
            busy     <= 1'b1;
            wait_cnt <= 2 + int'($unsigned($random(seed)) % 5);   // 2 to 6 cycles
        end else if (busy) begin
            if (wait_cnt == 1) begin
                busy         <= 1'b0;
                mmu_rdy_o    <= 1'b1;
                mmu_victim_o <= next_victim;
                next_victim  <= next_victim + 1'b1;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end
end

endmodule : mmu_model

// ==== dv/tl_tb.sv ====
module tl_tb;

timeunit 1ns;
timeprecision 100ps;

import tl_pkg::*;

localparam int NUM_LINES  = 4;
localparam int SB_DEPTH   = 4;
localparam int SLOT_W     = $clog2(NUM_LINES);
localparam int MAX_CYCLES = 2000;                      // ~120 ops at worst-case fill latency
localparam int OP_LD      = 0;
localparam int OP_ST      = 1;
localparam int OP_ALU     = 2;

logic              clk_i;
logic              arst_n;
ex_tl_t            ex_tl;
logic              stall_o;
tl_mem_t           tl_mem_o;
logic              mmu_req;
word_t             mmu_addr;
logic              mmu_rdy;
logic [SLOT_W-1:0] mmu_victim;

ex_tl_t    ops[$];                                     // Pending operations
ex_tl_t    issued[$];
integer    seed = 40910;
int        errors = 0;
logic      stall_seen = 1'b0;
tl_mem_t   exp_out = '0;
logic      exp_acc = 1'b0;                             // Output holds an accepted op

// Reference model state
tl_state_e mstate = TL_IDLE;
word_t     sb_addr_m[$];
word_t     sb_data_m[$];
line_tag_t slot_tag_m[NUM_LINES];
logic      slot_vld_m[NUM_LINES] = '{default: 1'b0};
line_tag_t miss_tag;

tl_stage #(
    .NUM_LINES (NUM_LINES),
    .SB_DEPTH  (SB_DEPTH)
) dut (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n),
    .ex_tl_i      (ex_tl),
    .stall_o      (stall_o),
    .tl_mem_o     (tl_mem_o),
    .mmu_req_o    (mmu_req),
    .mmu_addr_o   (mmu_addr),
    .mmu_rdy_i    (mmu_rdy),
    .mmu_victim_i (mmu_victim)
);

mmu_model #(
    .NUM_LINES (NUM_LINES)
) mmu (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n),
    .mmu_req_i    (mmu_req),
    .mmu_rdy_o    (mmu_rdy),
    .mmu_victim_o (mmu_victim)
);

initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
end

task automatic check_val(input string name, input logic [159:0] exp, input logic [159:0] act);
    if (exp !== act) begin
        errors++;
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic add_op(input int kind, input word_t addr, input word_t data);
    ex_tl_t op;
    op          = '0;
    op.alu_res  = addr;
    op.st_data  = data;
    op.memop_rd = (kind == OP_LD);
    op.memop_wr = (kind == OP_ST);
    op.rf_we    = (kind != OP_ST);
    op.rf_waddr = reg_addr_t'(ops.size() + 1);
    op.tkbr     = (ops.size() % 7 == 3);
    op.new_pc   = 32'h1000 + word_t'(ops.size()) * 32'd4;   // Unique per op
    ops.push_back(op);
endtask

function automatic logic carries(input tl_mem_t t);
    return t.memop_rd | t.memop_wr | t.sb_hit | t.rf_we | t.tkbr;
endfunction

// Returns the expected registered output and updates the model state
function automatic tl_mem_t ref_step(input ex_tl_t op, input tl_mem_t prev, input logic rdy,
                                     input logic [SLOT_W-1:0] victim,
                                     output logic stall, output logic req);
    tl_mem_t   exp;
    line_tag_t line;
    logic      fwd;
    logic      hit;
    logic      pop;
    word_t     fwd_val;
    exp          = prev;                                // Bubble keeps data fields
    exp.rf_we    = 1'b0;
    exp.memop_rd = 1'b0;
    exp.memop_wr = 1'b0;
    exp.tkbr     = 1'b0;
    exp.sb_hit   = 1'b0;
    line         = op.alu_res[WORD_SIZE-1:OFFSET_SIZE];
    fwd          = 1'b0;
    fwd_val      = '0;
    foreach (sb_addr_m[i]) begin
        if (sb_addr_m[i][WORD_SIZE-1:2] == op.alu_res[WORD_SIZE-1:2]) begin
            fwd     = 1'b1;
            fwd_val = sb_data_m[i];                     // Oldest to newest so the last match wins
        end
    end
    hit = 1'b0;
    for (int s = 0; s < NUM_LINES; s++) begin
        if (slot_vld_m[s] && slot_tag_m[s] == line) begin
            hit = 1'b1;
        end
    end
    stall = 1'b1;
    req   = 1'b0;
    pop   = 1'b0;
    case (mstate)
        TL_IDLE: begin
            if (op.memop_rd && !fwd && !hit) begin
                req      = 1'b1;
                miss_tag = line;
                mstate   = TL_MISS_WAIT;
            end else if (op.memop_wr && sb_addr_m.size() == SB_DEPTH) begin
                mstate = TL_SB_FULL;
            end else begin
                stall = 1'b0;
                pop   = !op.memop_rd && !op.memop_wr && sb_addr_m.size() > 0;
            end
        end
        TL_MISS_WAIT: begin
            req = 1'b1;
            if (rdy) begin
                slot_tag_m[victim] = miss_tag;
                slot_vld_m[victim] = 1'b1;
                mstate             = TL_IDLE;
            end
        end
        default: begin
            if (sb_addr_m.size() > 0) begin
                pop    = 1'b1;
                mstate = TL_IDLE;
            end
        end
    endcase
    if (!stall) begin
        exp.alu_res  = op.alu_res;
        exp.rf_we    = op.rf_we;
        exp.rf_waddr = op.rf_waddr;
        exp.tkbr     = op.tkbr;
        exp.new_pc   = op.new_pc;
        exp.mem_addr = op.alu_res;
        exp.mem_data = op.st_data;
        if (op.memop_rd && fwd) begin
            exp.sb_hit   = 1'b1;
            exp.mem_data = fwd_val;
        end else if (op.memop_rd) begin
            exp.memop_rd = 1'b1;
        end
        if (op.memop_wr) begin
            sb_addr_m.push_back(op.alu_res);
            sb_data_m.push_back(op.st_data);
        end
    end
    if (pop) begin
        exp.memop_wr = 1'b1;
        exp.mem_addr = sb_addr_m.pop_front();
        exp.mem_data = sb_data_m.pop_front();
    end
    return exp;
endfunction

always @(negedge clk_i) begin : compare
    tl_mem_t exp_now;
    logic    exp_stall;
    logic    exp_req;
    if (arst_n) begin
        if (exp_acc || carries(exp_out) || carries(tl_mem_o)) begin
            check_val("stage output", 160'(exp_out), 160'(tl_mem_o));
        end
        exp_now = ref_step(ex_tl, exp_out, mmu_rdy, mmu_victim, exp_stall, exp_req);
        check_val("stall", 160'(exp_stall), 160'(stall_o));
        check_val("mmu request", 160'(exp_req), 160'(mmu_req));
        if (exp_req) begin
            check_val("mmu address", 160'({ex_tl.alu_res[WORD_SIZE-1:OFFSET_SIZE], 4'h0}),
                      160'(mmu_addr));
        end
        exp_out    = exp_now;
        exp_acc    = !exp_stall;
        stall_seen = stall_o;                           // Handshake for the driver
    end
end

initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
        @(posedge clk_i);
        cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
    $display("Regression failed");
    $finish;
end

initial begin : main
    int idle_left;
    int kind;
    ex_tl  <= '0;
    arst_n <= 1'b0;
    add_op(OP_LD, 32'h100, '0);                         // Cold miss
    add_op(OP_LD, 32'h104, '0);                         // Same line, no request
    add_op(OP_ST, 32'h200, 32'hA5A5_0001);
    add_op(OP_LD, 32'h200, '0);
    add_op(OP_ST, 32'h200, 32'hA5A5_0002);
    add_op(OP_LD, 32'h200, '0);                         // Later store forwarded
    for (int i = 0; i < 3; i++) begin
        add_op(OP_ALU, 32'h55 + i, '0);                 // Drains in order
    end
    for (int i = 0; i < 5; i++) begin
        add_op(OP_ST, 32'h300 + 4 * i, 32'hC0DE_0000 + i);   // Fifth one stalls
    end
    for (int i = 0; i < 100; i++) begin
        kind = int'($unsigned($random(seed)) % 3);
        add_op(kind, 32'h400 + (($unsigned($random(seed)) % 24) << 2), word_t'($random(seed)));
    end
    repeat (4) @(posedge clk_i);
    arst_n <= 1'b1;
    @(negedge clk_i);
    check_val("reset output", '0, 160'(tl_mem_o));
    check_val("reset stall", '0, 160'(stall_o));
    check_val("reset mmu request", '0, 160'(mmu_req));
    while (ops.size() > 0) begin
        @(posedge clk_i);
        if (!stall_seen) begin
            issued.push_back(ops[0]);
            ex_tl <= ops.pop_front();
        end
    end
    idle_left = 8;                                      // Let the buffer empty
    while (idle_left > 0) begin
        @(posedge clk_i);
        if (!stall_seen) begin
            ex_tl <= '0;
            idle_left--;
        end
    end
    repeat (2) @(negedge clk_i);
    $display("Checks done: %0d operations issued, %0d errors", issued.size(), errors);
    if (errors == 0) begin
        $display("Regression passed");
    end else begin
        $display("Regression failed");
    end
    $finish;
end

endmodule : tl_tb

// ==== build.f ====
source/tl_pkg.sv
source/dcache_tag.sv
source/store_buffer.sv
source/tl_stage.sv
dv/mmu_model.sv
dv/tl_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tl_tb -Mdir obj_dir -o tl_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tl_tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
